/* common/geom_pkg.sv */
`default_nettype none

package geom_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Pixel word
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  localparam int word_width = 8;

  typedef logic [word_width-1:0] word_t;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Default engine geometry
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  localparam int units_default        = 8;  // Output words per beat
  localparam int kernel_h_max_default = 5;  // Must stay odd

  // Wide enough for kernel_h_1 of the largest supported kernel
  localparam int bits_kernel_h = 3;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Header beat layout
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // One field per word, value in the low bits of the word
  localparam int i_is_not_max = 0;
  localparam int i_is_max     = 1;
  localparam int i_is_lrelu   = 2;
  localparam int i_kernel_h_1 = 3;

endpackage

`default_nettype wire

/* common/stream_pkg.sv */
`default_nettype none

package stream_pkg;

  import geom_pkg::*;

  // Image configuration, sent alongside every image beat
  typedef struct packed {
    logic                     is_not_max;
    logic                     is_max;
    logic                     is_lrelu;
    logic [bits_kernel_h-1:0] kernel_h_1;  // Kernel height minus one
  } img_cfg_t;

  // Image pipe phases
  typedef enum logic [1:0] {
    set_s  = 2'd0,  // Waiting for the header beat
    ones_s = 2'd1,  // Activation config beats
    pass_s = 2'd2   // Image data
  } pipe_state_t;

  // Number of ones beats that follow a header
  function automatic logic [bits_kernel_h:0] ones_beats(
    input logic [bits_kernel_h-1:0] kernel_h_1
  );
    logic [bits_kernel_h:0] beats;
    beats = {1'b0, kernel_h_1} + 1'b1;
    return beats;
  endfunction

endpackage

`default_nettype wire

/* logic/reg_slice.sv */
`timescale 1ns/1ps
`default_nettype none

module reg_slice #(
  parameter type payload_t = logic
) (
  input  wire logic     aclk,
  input  wire logic     rst,
  input  wire logic     s_valid,
  input  wire payload_t s_data,
  input  wire logic     m_ready,
  output logic          s_ready,
  output logic          m_valid,
  output payload_t      m_data
);

  payload_t   mem [2];
  logic       wr_ptr, rd_ptr;
  logic [1:0] count;   // Entries held, 0 to 2
  logic       push, pop;

  assign push = s_valid && s_ready;
  assign pop  = m_valid && m_ready;

  // Ready looks only at occupancy, never at m_ready
  assign s_ready = count != 2'd2;
  assign m_valid = count != 2'd0;
  assign m_data  = mem[rd_ptr];

  always_ff @(posedge aclk) begin
    if (rst) begin
      wr_ptr <= 1'b0;
      rd_ptr <= 1'b0;
      count  <= 2'd0;
    end else begin
      if (push) wr_ptr <= ~wr_ptr;
      if (pop)  rd_ptr <= ~rd_ptr;
      count <= count + 2'(push) - 2'(pop);
    end
  end

  always_ff @(posedge aclk) begin
    if (push) mem[wr_ptr] <= s_data;
  end

  a_hold_stalled : assert property (@(posedge aclk) disable iff (rst)
    m_valid && !m_ready |=> m_valid && $stable(m_data));

endmodule

`default_nettype wire

/* image_pipe/image_pipe.sv */
`timescale 1ns/1ps
`default_nettype none

module image_pipe #(
  parameter int units        = 8,
  parameter int kernel_h_max = 5,
  localparam int units_edges = units + kernel_h_max - 1
) (
  input  wire logic                               aclk,
  input  wire logic                               rst,
  input  wire logic                               s1_valid,
  input  wire logic                               s1_last,
  input  wire geom_pkg::word_t [units_edges-1:0]  s1_data,
  input  wire logic                               s2_valid,
  input  wire geom_pkg::word_t [units_edges-1:0]  s2_data,
  input  wire logic                               p_ready,
  output logic                                    s1_ready,
  output logic                                    s2_ready,
  output logic                                    p_valid,
  output geom_pkg::word_t [units_edges-1:0]       p_data1,
  output geom_pkg::word_t [units_edges-1:0]       p_data2,
  output stream_pkg::img_cfg_t                    p_cfg,
  output logic                                    is_config
);

  import geom_pkg::*;
  import stream_pkg::*;

  pipe_state_t            state, state_next;
  img_cfg_t               cfg_q, cfg_d;
  logic [bits_kernel_h:0] ones_cnt;
  logic                   ones_last;
  logic                   s1_fire, hdr_take;

  assign s1_fire   = s1_valid && s1_ready;
  assign hdr_take  = (state == set_s) && s1_fire;
  assign ones_last = ones_cnt == ones_beats(cfg_q.kernel_h_1) - 1'b1;

  // Header fields, one per word
  assign cfg_d.is_not_max = s1_data[i_is_not_max][0];
  assign cfg_d.is_max     = s1_data[i_is_max][0];
  assign cfg_d.is_lrelu   = s1_data[i_is_lrelu][0];
  assign cfg_d.kernel_h_1 = s1_data[i_kernel_h_1][bits_kernel_h-1:0];

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // FSM
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_comb begin
    state_next = state;
    unique case (state)
      set_s:   if (s1_fire) state_next = ones_s;
      ones_s:  if (ones_last && p_ready) state_next = pass_s;
      default: if (s1_fire && s1_last) state_next = set_s;  // New header per image
    endcase
  end

  always_ff @(posedge aclk) begin
    if (rst) begin
      state    <= set_s;
      cfg_q    <= '0;
      ones_cnt <= '0;
    end else begin
      state <= state_next;
      if (hdr_take) cfg_q <= cfg_d;
      if (state != ones_s) ones_cnt <= '0;
      else if (p_ready)    ones_cnt <= ones_cnt + 1'b1;
    end
  end

  // Output decoder
  always_comb begin
    unique case (state)
      set_s: begin
        p_valid  = 1'b0;     // Header is swallowed here
        s1_ready = p_ready;
        s2_ready = 1'b0;
      end
      ones_s: begin
        p_valid  = 1'b1;
        s1_ready = 1'b0;
        s2_ready = 1'b0;
      end
      default: begin
        // Max mode consumes both streams in lock step
        p_valid  = cfg_q.is_max ? (s1_valid && s2_valid) : s1_valid;
        s1_ready = cfg_q.is_max ? (p_ready && s2_valid) : p_ready;
        s2_ready = cfg_q.is_max ? (p_ready && s1_valid) : 1'b0;
      end
    endcase
  end

  // Lane muxing, ones beats carry 1 in word 0 only
  always_comb begin
    for (int u = 0; u < units_edges; u++) begin
      if (state == ones_s) begin
        p_data1[u] = word_t'(u == 0);
        p_data2[u] = word_t'(u == 0);
      end else begin
        p_data1[u] = s1_data[u];
        p_data2[u] = cfg_q.is_max ? s2_data[u] : s1_data[u];
      end
    end
  end

  assign p_cfg     = cfg_q;
  assign is_config = state == ones_s;

  a_state_legal : assert property (@(posedge aclk) disable iff (rst)
    state inside {set_s, ones_s, pass_s});

  // Header must select exactly one lane mode by the time data flows
  a_mode_excl : assert property (@(posedge aclk) disable iff (rst)
    hdr_take |=> !(cfg_q.is_max && cfg_q.is_not_max));

endmodule

`default_nettype wire

/* shift_buffer/shift_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module shift_buffer #(
  parameter int units        = 8,
  parameter int kernel_h_max = 5,
  localparam int units_edges = units + kernel_h_max - 1
) (
  input  wire logic                               aclk,
  input  wire logic                               rst,
  input  wire logic                               in_valid,
  input  wire geom_pkg::word_t [units_edges-1:0]  in_data,
  input  wire stream_pkg::img_cfg_t               in_cfg,
  input  wire logic                               is_config,
  input  wire logic                               out_ready,
  output logic                                    in_ready,
  output logic                                    out_valid,
  output geom_pkg::word_t [units-1:0]             out_data,
  output stream_pkg::img_cfg_t                    out_cfg
);

  import geom_pkg::*;
  import stream_pkg::*;

  word_t [units_edges-1:0]  dec;    // De-centered input
  word_t [units_edges-1:0]  buf_q;
  logic [bits_kernel_h-1:0] count, count_d;
  logic                     valid_q, valid_d;
  img_cfg_t                 cfg_q, cfg_d;
  logic                     en;

  assign en = out_ready;  // Slice back-pressure stalls everything

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // De-centering
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // Input is padded for kernel_h_max around its center, shifting is one sided
  always_comb begin
    int src;
    for (int v = 0; v < units_edges; v++) begin
      src = v + kernel_h_max / 2 - int'(in_cfg.kernel_h_1 / 2);
      if (src >= 0 && src < units_edges) dec[v] = in_data[src];
      else                               dec[v] = '0;  // Past the input edge
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Load and shift control
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_comb begin
    if (count == '0) begin
      in_ready = out_ready;
      valid_d  = in_valid;
      cfg_d    = in_cfg;
      count_d  = (in_valid && !is_config) ? in_cfg.kernel_h_1 : '0;
    end else begin
      in_ready = 1'b0;     // Busy repeating the held beat
      valid_d  = 1'b1;
      cfg_d    = cfg_q;
      count_d  = count - 1'b1;
    end
  end

  always_ff @(posedge aclk) begin
    if (rst) begin
      count   <= '0;
      valid_q <= 1'b0;
    end else if (en) begin
      count   <= count_d;
      valid_q <= valid_d;
    end
  end

  always_ff @(posedge aclk) begin
    if (en) begin
      cfg_q <= cfg_d;
      if (count == '0) begin
        buf_q <= is_config ? in_data : dec;  // Config beats skip de-centering
      end else begin
        buf_q[units_edges-2:0] <= buf_q[units_edges-1:1];  // Top word holds
      end
    end
  end

  assign out_valid = valid_q;
  assign out_data  = buf_q[units-1:0];
  assign out_cfg   = cfg_q;

  // Loaded kernel height must fit inside the input padding
  a_kernel_fits : assert property (@(posedge aclk) disable iff (rst)
    in_valid && in_ready && !is_config |-> in_cfg.kernel_h_1 < kernel_h_max);

endmodule

`default_nettype wire

/* logic/conv_input_top.sv */
`timescale 1ns/1ps
`default_nettype none

module conv_input_top #(
  parameter int units        = geom_pkg::units_default,
  parameter int kernel_h_max = geom_pkg::kernel_h_max_default,
  localparam int units_edges = units + kernel_h_max - 1
) (
  input  wire logic                               aclk,
  input  wire logic                               rst,
  input  wire logic                               s1_valid,
  input  wire logic                               s1_last,
  input  wire geom_pkg::word_t [units_edges-1:0]  s1_data,
  input  wire logic                               s2_valid,
  input  wire geom_pkg::word_t [units_edges-1:0]  s2_data,
  output logic                                    s1_ready,
  output logic                                    s2_ready,
  input  wire logic                               m_ready,
  output logic                                    m_valid,
  output geom_pkg::word_t [units-1:0]             m_data,
  output stream_pkg::img_cfg_t                    m_cfg,
  output geom_pkg::word_t [units_edges-1:0]       m2_data
);

  import geom_pkg::*;
  import stream_pkg::*;

  typedef struct packed {
    word_t [units-1:0] data;
    img_cfg_t          cfg;
  } slice_t;

  logic                    p_valid, p_ready, is_config;
  word_t [units_edges-1:0] p_data1, p_data2;
  img_cfg_t                p_cfg;
  logic                    sb_valid, sb_ready;
  slice_t                  sb_beat, m_beat;

  image_pipe #(.units(units), .kernel_h_max(kernel_h_max)) i_pipe (
    .aclk, .rst, .s1_valid, .s1_last, .s1_data, .s2_valid, .s2_data, .p_ready,
    .s1_ready, .s2_ready, .p_valid, .p_data1, .p_data2, .p_cfg, .is_config
  );

  shift_buffer #(.units(units), .kernel_h_max(kernel_h_max)) i_shift (
    .aclk, .rst, .in_valid(p_valid), .in_data(p_data1), .in_cfg(p_cfg), .is_config,
    .out_ready(sb_ready), .in_ready(p_ready), .out_valid(sb_valid),
    .out_data(sb_beat.data), .out_cfg(sb_beat.cfg)
  );

  reg_slice #(.payload_t(slice_t)) i_slice (
    .aclk, .rst, .s_valid(sb_valid), .s_data(sb_beat), .m_ready,
    .s_ready(sb_ready), .m_valid, .m_data(m_beat)
  );

  assign m_data = m_beat.data;
  assign m_cfg  = m_beat.cfg;

  // Unregistered side lane, valid together with the pipe output handshake
  assign m2_data = p_data2;

endmodule

`default_nettype wire

/* testbench/tb_checks.svh */
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH
`default_nettype none

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Error counters
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  int err_data  = 0;  // Pixel word mismatches
  int err_cfg   = 0;  // Config field mismatches
  int err_other = 0;  // Protocol and ordering problems

  // Linear congruential step, 32-bit state
  function automatic logic [31:0] lcg_step(input logic [31:0] state);
    return state * 32'd1103515245 + 32'd12345;
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Compare tasks
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // Only the low n words take part in the compare
  task automatic check_data(
    input string name,
    input wide_t got,
    input wide_t exp,
    input int    n
  );
    logic bad;
    bad = 1'b0;
    for (int i = 0; i < n; i++) begin
      if (got[i] !== exp[i]) begin
        bad = 1'b1;
      end
    end
    if (bad) begin
      err_data++;
      $display("Fail %s at %0t ns: got %h expected %h", name, $time, got, exp);
    end
  endtask

  task automatic check_cfg(
    input string    name,
    input img_cfg_t got,
    input img_cfg_t exp
  );
    if (got !== exp) begin
      err_cfg++;
      $display("Fail %s at %0t ns: got %h expected %h", name, $time, got, exp);
    end
  endtask

  task automatic report_error(input string msg);
    err_other++;
    $display("Error at %0t ns: %s", $time, msg);
  endtask

  function automatic int error_total();
    return err_data + err_cfg + err_other;
  endfunction

`default_nettype wire
`endif

/* testbench/tb_conv_input.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_conv_input;

  import geom_pkg::*;
  import stream_pkg::*;

  localparam int units        = units_default;
  localparam int kernel_h_max = kernel_h_max_default;
  localparam int units_edges  = units + kernel_h_max - 1;
  localparam int clk_period   = 8;
  localparam int in_beats     = 41;  // Input beats of all tests, headers included
  localparam int wd_cycles    = 5 + in_beats * kernel_h_max * 20;

  typedef word_t [units_edges-1:0] wide_t;
  typedef word_t [units-1:0]       narrow_t;

  logic        aclk = 1'b0;
  logic        rst;
  logic        s1_valid, s1_last, s2_valid;
  wide_t       s1_data, s2_data;
  logic        s1_ready, s2_ready;
  logic        m_ready = 1'b1;
  logic        m_valid;
  narrow_t     m_data;
  img_cfg_t    m_cfg;
  wide_t       m2_data;
  logic        bp_on, bp_now;
  logic [31:0] pix_seed = 32'd4372;
  logic [31:0] bp_seed  = 32'd4372;
  narrow_t     exp_data_q[$];  // Expected m_data, in order
  img_cfg_t    exp_cfg_q[$];

  `include "tb_checks.svh"

  conv_input_top #(.units(units), .kernel_h_max(kernel_h_max)) i_dut (
    .aclk, .rst, .s1_valid, .s1_last, .s1_data, .s2_valid, .s2_data,
    .s1_ready, .s2_ready, .m_ready, .m_valid, .m_data, .m_cfg, .m2_data
  );

  always #(clk_period / 2) aclk = ~aclk;

  // Random back-pressure on the output
  always @(posedge aclk) begin
    bp_now = bp_on;
    #1;
    if (bp_now) begin
      bp_seed = lcg_step(bp_seed);
      m_ready = bp_seed[20];
    end else begin
      m_ready = 1'b1;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Model of the image path
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  function automatic wide_t decenter(input wide_t d, input int kh1);
    wide_t dv;
    int    src;
    for (int v = 0; v < units_edges; v++) begin
      src = v + kernel_h_max / 2 - kh1 / 2;
      dv[v] = (src >= 0 && src < units_edges) ? d[src] : '0;
    end
    return dv;
  endfunction

  // One input beat gives kernel_h_1+1 shifted copies, config beats give one as is
  task automatic model_beat(input img_cfg_t cfg, input wide_t d, input logic is_cfg);
    wide_t   dv;
    narrow_t o;
    int      reps;
    dv   = is_cfg ? d : decenter(d, int'(cfg.kernel_h_1));
    reps = is_cfg ? 1 : int'(cfg.kernel_h_1) + 1;
    for (int j = 0; j < reps; j++) begin
      for (int i = 0; i < units; i++) begin
        o[i] = (i + j < units_edges) ? dv[i + j] : '0;
      end
      exp_data_q.push_back(o);
      exp_cfg_q.push_back(cfg);
    end
  endtask

  task automatic random_beat(output wide_t d);
    for (int i = 0; i < units_edges; i++) begin
      pix_seed = lcg_step(pix_seed);
      d[i]     = pix_seed[23:16];
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Stimulus
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // Entered and left 1 ns after a rising edge
  task automatic send_beat(
    input wide_t d1,
    input wide_t d2,
    input logic  last,
    input logic  use_s2,
    input logic  chk_m2,
    input wide_t exp_m2
  );
    logic took;
    s1_valid = 1'b1;
    s1_data  = d1;
    s1_last  = last;
    s2_valid = use_s2;
    s2_data  = d2;
    do begin
      @(negedge aclk);
      took = s1_ready && (!use_s2 || s2_ready);
      if (use_s2 && s1_ready != s2_ready) begin
        report_error("s1_ready and s2_ready differ in max mode");
      end
      if (took && chk_m2) begin
        check_data("m2_data", m2_data, exp_m2, units_edges);
      end
      @(posedge aclk);
      #1;
    end while (!took);
    s1_valid = 1'b0;
    s2_valid = 1'b0;
    s1_last  = 1'b0;
  endtask

  task automatic send_image(input logic max, input logic lrelu, input int kh1, input int n);
    img_cfg_t cfg;
    wide_t    hdr, ones, d1, d2;
    cfg.is_not_max = !max;
    cfg.is_max     = max;
    cfg.is_lrelu   = lrelu;
    cfg.kernel_h_1 = bits_kernel_h'(kh1);
    random_beat(hdr);
    hdr[i_is_not_max] = word_t'(cfg.is_not_max);
    hdr[i_is_max]     = word_t'(cfg.is_max);
    hdr[i_is_lrelu]   = word_t'(cfg.is_lrelu);
    hdr[i_kernel_h_1] = word_t'(cfg.kernel_h_1);
    ones    = '0;
    ones[0] = 8'd1;
    for (int k = 0; k <= kh1; k++) begin
      model_beat(cfg, ones, 1'b1);
    end
    send_beat(hdr, '0, 1'b0, 1'b0, 1'b0, '0);
    for (int b = 0; b < n; b++) begin
      random_beat(d1);
      random_beat(d2);
      model_beat(cfg, d1, 1'b0);
      send_beat(d1, d2, b == n - 1, max, 1'b1, max ? d2 : d1);
    end
  endtask

  task automatic wait_drain();
    while (exp_data_q.size() != 0) begin
      @(posedge aclk);
    end
    repeat (8) @(posedge aclk);  // Catch stray extra beats
    #1;
  endtask

  // Output checker, a beat transfers at the edge after this sample
  always @(negedge aclk) begin : out_monitor
    wide_t    got_w;
    wide_t    exp_w;
    img_cfg_t exp_c;
    if (!rst && m_valid && m_ready) begin
      if (exp_data_q.size() == 0) begin
        report_error("output beat arrived with no beat expected");
      end else begin
        got_w            = '0;
        got_w[units-1:0] = m_data;
        exp_w            = '0;
        exp_w[units-1:0] = exp_data_q.pop_front();
        exp_c            = exp_cfg_q.pop_front();
        check_data("m_data", got_w, exp_w, units);
        check_cfg("m_cfg", m_cfg, exp_c);
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Directed tests
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic test_reset_ones();
    @(negedge aclk);
    if (m_valid !== 1'b0) begin
      report_error("m_valid is not low after reset");
    end
    @(posedge aclk);
    #1;
    send_image(1'b0, 1'b1, 4, 2);  // Five ones beats ahead of the data
    wait_drain();
  endtask

  task automatic test_nonmax_k3();
    send_image(1'b0, 1'b0, 2, 4);
    wait_drain();
  endtask

  task automatic test_max();
    send_image(1'b1, 1'b1, 2, 4);
    wait_drain();
  endtask

  task automatic test_kernel_heights();
    send_image(1'b0, 1'b0, 0, 3);
    send_image(1'b1, 1'b0, 4, 3);
    wait_drain();
  endtask

  task automatic test_backpressure();
    bp_on = 1'b1;
    send_image(1'b0, 1'b1, 2, 6);
    send_image(1'b1, 1'b0, 4, 4);
    wait_drain();
    bp_on = 1'b0;
  endtask

  // Second header must replace the first one
  task automatic test_two_images();
    send_image(1'b1, 1'b0, 0, 3);
    send_image(1'b0, 1'b1, 4, 3);
    wait_drain();
  endtask

  initial begin
    rst      = 1'b1;
    s1_valid = 1'b0;
    s1_last  = 1'b0;
    s1_data  = '0;
    s2_valid = 1'b0;
    s2_data  = '0;
    bp_on    = 1'b0;
    repeat (5) @(posedge aclk);
    #1;
    rst = 1'b0;
    test_reset_ones();
    test_nonmax_k3();
    test_max();
    test_kernel_heights();
    test_backpressure();
    test_two_images();
    $display("Errors: data %0d, cfg %0d, other %0d", err_data, err_cfg, err_other);
    if (error_total() == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  initial begin
    #(wd_cycles * clk_period);
    $display("Watchdog expired after %0d cycles, %0d beats still expected",
             wd_cycles, exp_data_q.size());
    $display("Test failures found");
    $finish;
  end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+testbench
common/geom_pkg.sv
common/stream_pkg.sv
logic/reg_slice.sv
image_pipe/image_pipe.sv
shift_buffer/shift_buffer.sv
logic/conv_input_top.sv
testbench/tb_conv_input.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the conv input testbench with Verilator

set -u
cd "$(dirname "$0")" || exit 1

obj_dir=obj_dir
sim_bin=sim_conv_input
log=sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f vlog.f --top-module tb_conv_input \
  -Mdir "$obj_dir" -o "$sim_bin"
if [ $? -ne 0 ]; then
  echo "Build failed"
  exit 1
fi

"./$obj_dir/$sim_bin" > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "All tests passed!" "$log"; then
  echo "PASS"
  exit 0
else
  echo "FAIL"
  exit 1
fi
